// File: vsi_modulation.f
source/pwm_register_map_pkg.sv
source/modulation_control_pkg.sv
source/command_sequencer.sv
source/compare_calculator.sv
source/write_arbiter.sv
source/vsi_modulation_top.sv
verification/clock_reset_gen.sv
verification/vsi_modulation_tb.sv

// File: verification/vsi_modulation_tb.sv
// Drives host commands into the modulation front end and checks every write on the output port
// Expected writes come from the register map rules, with the PWM base fixed at 0x4000
// Commands are only issued once all earlier writes have left, since the DUT drops busy commands
`timescale 1ns/1ps
`default_nettype none

module vsi_modulation_tb
    import modulation_control_pkg::*;
();

    localparam logic [31:0] BASE_ADDR = 32'h4000;
    localparam int N_PHASES = 4;
    localparam int N_PWM_CHANNELS = 4;
    localparam int UPDATE_ROUNDS = 6;
    localparam int MAX_STALL = 6;
    localparam int IDLE_CYCLES = 20;
    // Writes of all tests together, used to size the watchdog
    localparam int TOTAL_WRITES = 3 + 2 + 9 * UPDATE_ROUNDS + 11 + (9 * 3 + 2) + 12;
    localparam int WATCHDOG_NS = (TOTAL_WRITES * (MAX_STALL + 4) + IDLE_CYCLES + 200) * 10;

    logic clock;
    logic reset;
    logic configure;
    logic start;
    logic stop;
    logic [3:0] update;
    duty_t period;
    duty_t duty [N_PHASES];
    logic write_ready;
    logic [31:0] write_dest;
    logic [31:0] write_data;
    logic write_valid;
    logic done;
    modulator_status_t modulator_status;

    logic [31:0] expected_dest [$];
    logic [31:0] expected_data [$];
    logic [31:0] head_dest;
    logic [31:0] head_data;
    logic [31:0] stim_state = 32'h9c9;
    logic [31:0] stall_state = 32'h9c9;
    int stall_left = 0;
    int stall_rate = 4;
    int transfer_count = 0;
    int done_count = 0;
    int saved_count;
    string current_test = "reset";

    clock_reset_gen clock_reset_gen_i (
        .clock(clock),
        .reset(reset)
    );

    vsi_modulation_top #(
        .PWM_BASE_ADDR(BASE_ADDR),
        .N_PHASES(N_PHASES),
        .N_PWM_CHANNELS(N_PWM_CHANNELS)
    ) dut_i (
        .clock(clock),
        .reset(reset),
        .configure(configure),
        .start(start),
        .stop(stop),
        .update(update),
        .period(period),
        .duty(duty),
        .write_ready(write_ready),
        .write_dest(write_dest),
        .write_data(write_data),
        .write_valid(write_valid),
        .done(done),
        .modulator_status(modulator_status)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_stimulus();
        stim_state = xorshift(stim_state);
        return stim_state;
    endfunction

    // Register n above the compare block, which starts 0x100 past the base
    function automatic logic [31:0] register_address(input int unsigned n);
        return BASE_ADDR + 32'h100 + 32'(4 * n);
    endfunction

    task automatic report_mismatch(input string test_name, input string what,
                                   input logic [31:0] expected, input logic [31:0] actual);
        $display("** Error [%s] %s: expected %h, actual %h", test_name, what, expected, actual);
        $display("TEST FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic report_problem(input string test_name, input string what);
        $display("Failure in %s: %s", test_name, what);
        $display("TEST FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic expect_write(input logic [31:0] dest, input logic [31:0] data);
        expected_dest.push_back(dest);
        expected_data.push_back(data);
    endtask

    task automatic expect_configuration();
        expect_write(BASE_ADDR, 32'h1100);
        expect_write(register_address(3 * N_PWM_CHANNELS + 5), 32'h1);
        expect_write(register_address(3 * N_PWM_CHANNELS + 3), 32'hff);
    endtask

    // Period first, then the centre-aligned low and high pair of each phase
    task automatic expect_burst();
        logic [31:0] half_period;
        logic [31:0] half_duty;
        half_period = 32'(period >> 1);
        expect_write(register_address(3 * N_PWM_CHANNELS + 1), 32'(period));
        for (int i = 0; i < N_PHASES; i++) begin
            half_duty = 32'(duty[i] >> 1);
            expect_write(register_address(i), half_period - half_duty);
            expect_write(register_address(i + N_PWM_CHANNELS), half_period + half_duty);
        end
    endtask

    task automatic randomize_inputs();
        period = duty_t'(next_stimulus());
        for (int i = 0; i < N_PHASES; i++) begin
            duty[i] = duty_t'(next_stimulus() % (32'(period) + 32'd1));
        end
    endtask

    // All pulse tasks start and end on a falling edge
    task automatic pulse_configure();
        configure = 1'b1;
        @(negedge clock);
        configure = 1'b0;
    endtask

    task automatic pulse_start();
        start = 1'b1;
        @(negedge clock);
        start = 1'b0;
    endtask

    task automatic pulse_stop();
        stop = 1'b1;
        @(negedge clock);
        stop = 1'b0;
    endtask

    task automatic pulse_update();
        update = 4'b0001 << (next_stimulus() % 4);
        @(negedge clock);
        update = 4'b0000;
    endtask

    task automatic wait_drained();
        while (expected_dest.size() != 0) begin
            @(negedge clock);
        end
    endtask

    task automatic run_update_rounds(input int rounds);
        repeat (rounds) begin
            randomize_inputs();
            expect_burst();
            pulse_update();
            wait_drained();
        end
    endtask

    // Ready stalls last 1 to MAX_STALL cycles and are followed by at least one ready cycle
    always @(negedge clock) begin
        if (stall_left > 1) begin
            write_ready = 1'b0;
            stall_left = stall_left - 1;
        end else if (stall_left == 1) begin
            write_ready = 1'b1;
            stall_left = 0;
        end else begin
            stall_state = xorshift(stall_state);
            if (int'(stall_state[3:0]) < stall_rate) begin
                write_ready = 1'b0;
                stall_left = int'(stall_state[11:4]) % MAX_STALL + 1;
            end else begin
                write_ready = 1'b1;
            end
        end
    end

    always @(posedge clock) begin
        if (reset && done) begin
            done_count = done_count + 1;
        end
        if (reset && write_valid && write_ready) begin
            transfer_count = transfer_count + 1;
            stray_write: assert (expected_dest.size() != 0)
                else report_problem(current_test, "a write appeared when none was expected");
            if (expected_dest.size() != 0) begin
                head_dest = expected_dest.pop_front();
                head_data = expected_data.pop_front();
                dest_match: assert (write_dest == head_dest)
                    else report_mismatch(current_test, "write_dest", head_dest, write_dest);
                data_match: assert (write_data == head_data)
                    else report_mismatch(current_test, "write_data", head_data, write_data);
            end
        end
    end

    output_held: assert property (
        @(posedge clock) disable iff (!reset)
        write_valid && !write_ready |=>
            write_valid && $stable(write_dest) && $stable(write_data)
    ) else report_problem(current_test, "a stalled write changed or vanished before acceptance");

    done_single: assert property (
        @(posedge clock) disable iff (!reset) done |=> !done
    ) else report_problem(current_test, "done stayed high for more than one cycle");

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired in %s with %0d writes still expected",
                 current_test, expected_dest.size());
        $display("TEST FAILED");
        $fatal(1, "run did not finish in time");
    end

    initial begin
        configure = 1'b0;
        start = 1'b0;
        stop = 1'b0;
        update = 4'b0000;
        period = '0;
        write_ready = 1'b0;
        for (int i = 0; i < N_PHASES; i++) begin
            duty[i] = '0;
        end
        wait (reset);
        @(negedge clock);

        current_test = "configure";
        expect_configuration();
        pulse_configure();
        wait_drained();
        done_once: assert (done_count == 1)
            else report_mismatch(current_test, "done pulses", 32'd1, 32'(done_count));

        current_test = "start_stop";
        expect_write(BASE_ADDR, 32'h1128);
        pulse_start();
        wait_drained();
        status_on: assert (modulator_status == modulator_on)
            else report_mismatch(current_test, "modulator_status", 32'd1, 32'(modulator_status));
        expect_write(BASE_ADDR, 32'h1100);
        pulse_stop();
        wait_drained();
        status_off: assert (modulator_status == modulator_off)
            else report_mismatch(current_test, "modulator_status", 32'd0, 32'(modulator_status));

        current_test = "update_off";
        run_update_rounds(UPDATE_ROUNDS);

        // The update must wait until stop, and the stop write goes out ahead of the burst
        current_test = "update_running";
        expect_write(BASE_ADDR, 32'h1128);
        pulse_start();
        wait_drained();
        saved_count = transfer_count;
        randomize_inputs();
        pulse_update();
        repeat (IDLE_CYCLES) @(negedge clock);
        held_while_running: assert (transfer_count == saved_count)
            else report_mismatch(current_test, "writes while running",
                                 32'(saved_count), 32'(transfer_count));
        expect_write(BASE_ADDR, 32'h1100);
        expect_burst();
        pulse_stop();
        wait_drained();

        current_test = "back_pressure";
        stall_rate = 11;
        run_update_rounds(3);
        expect_write(BASE_ADDR, 32'h1128);
        pulse_start();
        wait_drained();
        expect_write(BASE_ADDR, 32'h1100);
        pulse_stop();
        wait_drained();
        stall_rate = 4;

        // Configure lands once the burst is under way, so its writes queue behind it
        current_test = "priority";
        randomize_inputs();
        expect_burst();
        pulse_update();
        saved_count = transfer_count;
        while (transfer_count == saved_count) begin
            @(negedge clock);
        end
        expect_configuration();
        pulse_configure();
        wait_drained();
        done_twice: assert (done_count == 2)
            else report_mismatch(current_test, "done pulses", 32'd2, 32'(done_count));

        repeat (IDLE_CYCLES) @(negedge clock);
        nothing_left: assert (expected_dest.size() == 0)
            else report_problem(current_test, "expected writes never reached the output");
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/clock_reset_gen.sv
// Free-running testbench clock and an active-low synchronous reset
// Reset is released on a falling edge so that it is stable at the next rising edge
`timescale 1ns/1ps
`default_nettype none

module clock_reset_gen #(
    parameter int PERIOD_NS = 10,
    parameter int RESET_CYCLES = 2
) (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #(PERIOD_NS / 2) clock = ~clock;
    end

    initial begin
        reset = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        reset = 1'b1;
    end

endmodule

`default_nettype wire

// File: source/vsi_modulation_top.sv
// Front end of the inverter modulator, producing register writes for a PWM generator
// write_ready may stall at any time, so output latency is not fixed
`timescale 1ns/1ps
`default_nettype none

module vsi_modulation_top
    import modulation_control_pkg::*;
#(
    parameter logic [31:0] PWM_BASE_ADDR = 32'h0,
    parameter int N_PHASES = 4,
    parameter int N_PWM_CHANNELS = 4
) (
    input  wire logic          clock,
    input  wire logic          reset,
    input  wire logic          configure,
    input  wire logic          start,
    input  wire logic          stop,
    input  wire logic [3:0]    update,
    input  duty_t              period,
    input  duty_t              duty [N_PHASES],
    input  wire logic          write_ready,
    output logic [31:0]        write_dest,
    output write_word_t        write_data,
    output logic               write_valid,
    output logic               done,
    output modulator_status_t  modulator_status
);

    write_offset_t seq_offset;
    write_word_t seq_data;
    logic seq_valid;
    logic seq_ready;

    write_offset_t calc_offset;
    write_word_t calc_data;
    logic calc_valid;
    logic calc_ready;
    logic calc_last;

    command_sequencer #(
        .N_PWM_CHANNELS(N_PWM_CHANNELS)
    ) command_sequencer_i (
        .clock(clock),
        .reset(reset),
        .configure(configure),
        .start(start),
        .stop(stop),
        .seq_ready(seq_ready),
        .seq_offset(seq_offset),
        .seq_data(seq_data),
        .seq_valid(seq_valid),
        .done(done),
        .modulator_status(modulator_status)
    );

    compare_calculator #(
        .N_PHASES(N_PHASES),
        .N_PWM_CHANNELS(N_PWM_CHANNELS)
    ) compare_calculator_i (
        .clock(clock),
        .reset(reset),
        .update(update),
        .period(period),
        .duty(duty),
        .modulator_status(modulator_status),
        .calc_ready(calc_ready),
        .calc_offset(calc_offset),
        .calc_data(calc_data),
        .calc_valid(calc_valid),
        .calc_last(calc_last)
    );

    write_arbiter #(
        .PWM_BASE_ADDR(PWM_BASE_ADDR)
    ) write_arbiter_i (
        .clock(clock),
        .reset(reset),
        .seq_offset(seq_offset),
        .seq_data(seq_data),
        .seq_valid(seq_valid),
        .seq_ready(seq_ready),
        .calc_offset(calc_offset),
        .calc_data(calc_data),
        .calc_valid(calc_valid),
        .calc_last(calc_last),
        .calc_ready(calc_ready),
        .write_dest(write_dest),
        .write_data(write_data),
        .write_valid(write_valid),
        .write_ready(write_ready)
    );

endmodule

`default_nettype wire

// File: source/write_arbiter.sv
// Merges sequencer and calculator writes onto the external write port
// Sequencer wins between streams, but a started calculator burst runs to its last write
// One cycle of latency through the output register, full throughput when ready stays high
`timescale 1ns/1ps
`default_nettype none

module write_arbiter
    import modulation_control_pkg::*;
#(
    parameter logic [31:0] PWM_BASE_ADDR = 32'h0
) (
    input  wire logic      clock,
    input  wire logic      reset,
    input  write_offset_t  seq_offset,
    input  write_word_t    seq_data,
    input  wire logic      seq_valid,
    output logic           seq_ready,
    input  write_offset_t  calc_offset,
    input  write_word_t    calc_data,
    input  wire logic      calc_valid,
    input  wire logic      calc_last,
    output logic           calc_ready,
    output logic [31:0]    write_dest,
    output write_word_t    write_data,
    output logic           write_valid,
    input  wire logic      write_ready
);

    logic burst_lock;
    logic out_free;
    logic seq_accept;
    logic calc_accept;

    // Output register can take a new write if empty or draining this cycle
    assign out_free = !write_valid || write_ready;

    assign seq_ready = out_free && !burst_lock && seq_valid;
    assign calc_ready = out_free && (burst_lock || !seq_valid);

    assign seq_accept = seq_valid && seq_ready;
    assign calc_accept = calc_valid && calc_ready;

    always_ff @(posedge clock) begin
        if (!reset) begin
            write_valid <= 1'b0;
            burst_lock <= 1'b0;
        end else begin
            if (seq_accept || calc_accept) begin
                write_valid <= 1'b1;
            end else if (write_ready) begin
                write_valid <= 1'b0;
            end

            // Hold the grant on the calculator until its last write passes
            if (calc_accept) begin
                burst_lock <= !calc_last;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (seq_accept) begin
            write_dest <= PWM_BASE_ADDR + seq_offset;
            write_data <= seq_data;
        end else if (calc_accept) begin
            write_dest <= PWM_BASE_ADDR + calc_offset;
            write_data <= calc_data;
        end
    end

    write_valid_held: assert property (
        @(posedge clock) disable iff (!reset)
        write_valid && !write_ready |=>
            write_valid && $stable(write_dest) && $stable(write_data)
    );

    // No sequencer write may slip into the middle of a compare burst
    burst_not_split: assert property (
        @(posedge clock) disable iff (!reset)
        calc_accept && !calc_last |=> !seq_accept until_with (calc_accept && calc_last)
    );

endmodule

`default_nettype wire

// File: source/compare_calculator.sv
// Computes centre-aligned compare pairs and streams them as one write burst
// Updates are only served while the modulator is off, otherwise they wait
// Duty larger than the period wraps the low compare value
`timescale 1ns/1ps
`default_nettype none

module compare_calculator
    import pwm_register_map_pkg::*;
    import modulation_control_pkg::*;
#(
    parameter int N_PHASES = 4,
    parameter int N_PWM_CHANNELS = 4
) (
    input  wire logic              clock,
    input  wire logic              reset,
    input  wire logic [3:0]        update,
    input  duty_t                  period,
    input  duty_t                  duty [N_PHASES],
    input  modulator_status_t      modulator_status,
    input  wire logic              calc_ready,
    output write_offset_t          calc_offset,
    output write_word_t            calc_data,
    output logic                   calc_valid,
    output logic                   calc_last
);

    // One period write followed by a low and high compare per phase
    localparam int BURST_LENGTH = 1 + 2 * N_PHASES;
    localparam int INDEX_WIDTH = $clog2(BURST_LENGTH);
    localparam logic [INDEX_WIDTH-1:0] LAST_INDEX = INDEX_WIDTH'(BURST_LENGTH - 1);

    logic update_pending;
    logic start_calc;
    logic calc_accept;
    logic [INDEX_WIDTH-1:0] burst_index;
    logic [INDEX_WIDTH-1:0] compare_index;
    duty_t half_period;
    duty_t compare_low [N_PHASES];
    duty_t compare_high [N_PHASES];
    write_word_t burst_data [BURST_LENGTH];

    // The calculator is idle whenever no burst is being presented
    assign start_calc = update_pending && modulator_status == modulator_off && !calc_valid;
    assign calc_accept = calc_valid && calc_ready;

    assign half_period = period >> 1;

    always_comb begin
        for (int i = 0; i < N_PHASES; i++) begin
            compare_low[i] = half_period - (duty[i] >> 1);
            compare_high[i] = half_period + (duty[i] >> 1);
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            update_pending <= 1'b0;
            calc_valid <= 1'b0;
            burst_index <= '0;
        end else begin
            // A fresh update in the serving cycle keeps the flag set
            update_pending <= (update_pending && !start_calc) || (|update);
            if (start_calc) begin
                calc_valid <= 1'b1;
                burst_index <= '0;
            end else if (calc_accept) begin
                if (burst_index == LAST_INDEX) begin
                    calc_valid <= 1'b0;
                end else begin
                    burst_index <= burst_index + 1'b1;
                end
            end
        end
    end

    // Values are captured once and stay put for the whole burst
    always_ff @(posedge clock) begin
        if (start_calc) begin
            burst_data[0] <= write_word_t'(period);
            for (int i = 0; i < N_PHASES; i++) begin
                burst_data[1 + 2 * i] <= write_word_t'(compare_low[i]);
                burst_data[2 + 2 * i] <= write_word_t'(compare_high[i]);
            end
        end
    end

    // Odd compare positions carry the low value, even ones the high value
    assign compare_index = burst_index - 1'b1;

    always_comb begin
        if (burst_index == '0) begin
            calc_offset = period_offset(N_PWM_CHANNELS);
        end else if (compare_index[0]) begin
            calc_offset = compare_high_offset(compare_index >> 1, N_PWM_CHANNELS);
        end else begin
            calc_offset = compare_low_offset(compare_index >> 1);
        end
    end

    assign calc_data = burst_data[burst_index];
    assign calc_last = burst_index == LAST_INDEX;

    calc_valid_held: assert property (
        @(posedge clock) disable iff (!reset)
        calc_valid && !calc_ready |=> calc_valid && $stable(calc_offset) && $stable(calc_data)
    );

endmodule

`default_nettype wire

// File: source/command_sequencer.sv
// Turns configure, start and stop pulses into PWM register writes
// Commands arriving while a write is still outstanding are dropped
// When several commands come together, configure wins over start, start over stop
`timescale 1ns/1ps
`default_nettype none

module command_sequencer
    import pwm_register_map_pkg::*;
    import modulation_control_pkg::*;
#(
    parameter int N_PWM_CHANNELS = 4
) (
    input  wire logic              clock,
    input  wire logic              reset,
    input  wire logic              configure,
    input  wire logic              start,
    input  wire logic              stop,
    input  wire logic              seq_ready,
    output write_offset_t          seq_offset,
    output write_word_t            seq_data,
    output logic                   seq_valid,
    output logic                   done,
    output modulator_status_t      modulator_status
);

    typedef enum logic [1:0] {
        seq_idle,
        seq_configuring,
        seq_control
    } seq_state_t;

    seq_state_t seq_state;
    logic [1:0] config_index;
    logic seq_accept;

    assign seq_accept = seq_valid && seq_ready;

    always_ff @(posedge clock) begin
        if (!reset) begin
            seq_state <= seq_idle;
            config_index <= 2'd0;
            seq_valid <= 1'b0;
            done <= 1'b0;
            modulator_status <= modulator_off;
        end else begin
            done <= 1'b0;
            case (seq_state)
                seq_idle: begin
                    if (configure) begin
                        config_index <= 2'd0;
                        seq_valid <= 1'b1;
                        seq_state <= seq_configuring;
                    end else if (start) begin
                        modulator_status <= modulator_on;
                        seq_valid <= 1'b1;
                        seq_state <= seq_control;
                    end else if (stop) begin
                        modulator_status <= modulator_off;
                        seq_valid <= 1'b1;
                        seq_state <= seq_control;
                    end
                end
                seq_configuring: begin
                    if (seq_accept) begin
                        if (config_index == 2'd2) begin
                            // Last setup write has gone, report completion next cycle
                            seq_valid <= 1'b0;
                            done <= 1'b1;
                            seq_state <= seq_idle;
                        end else begin
                            config_index <= config_index + 2'd1;
                        end
                    end
                end
                seq_control: begin
                    if (seq_accept) begin
                        seq_valid <= 1'b0;
                        seq_state <= seq_idle;
                    end
                end
                default: seq_state <= seq_idle;
            endcase
        end
    end

    // Payload follows the same decisions as the FSM above
    always_ff @(posedge clock) begin
        if (seq_state == seq_idle) begin
            if (configure) begin
                seq_offset <= config_offset(0, N_PWM_CHANNELS);
                seq_data <= config_word(0);
            end else if (start) begin
                seq_offset <= ctrl_offset;
                seq_data <= ctrl_enable_word;
            end else if (stop) begin
                seq_offset <= ctrl_offset;
                seq_data <= ctrl_disable_word;
            end
        end else if (seq_state == seq_configuring && seq_accept && config_index != 2'd2) begin
            seq_offset <= config_offset(config_index + 2'd1, N_PWM_CHANNELS);
            seq_data <= config_word(config_index + 2'd1);
        end
    end

    start_stop_exclusive: assert property (
        @(posedge clock) disable iff (!reset) !(start && stop)
    );

    seq_valid_held: assert property (
        @(posedge clock) disable iff (!reset)
        seq_valid && !seq_ready |=> seq_valid && $stable(seq_offset) && $stable(seq_data)
    );

endmodule

`default_nettype wire

// File: source/modulation_control_pkg.sv
// Types shared by the modulation front end blocks
// Offsets are relative to the PWM base, which is added only at the output port
`default_nettype none

package modulation_control_pkg;

    localparam int write_width = 32;
    localparam int duty_width = 16;

    // Modulator run state as seen by the host and the compare calculator
    typedef enum logic {
        modulator_off = 1'b0,
        modulator_on = 1'b1
    } modulator_status_t;

    // Register offset before the base address is applied
    typedef logic [write_width-1:0] write_offset_t;

    typedef logic [write_width-1:0] write_word_t;

    // Period and duty are counts of the PWM timer clock
    typedef logic [duty_width-1:0] duty_t;

endpackage

`default_nettype wire

// File: source/pwm_register_map_pkg.sv
// Register map of the external PWM generator, as offsets from its base address
// Offsets assume the generator's 32-bit register stride of 4 bytes
`default_nettype none

package pwm_register_map_pkg;

    // Control register and the words that switch the modulator
    localparam logic [31:0] ctrl_offset = 32'h0;
    localparam logic [31:0] ctrl_enable_word = 32'h1128;
    localparam logic [31:0] ctrl_disable_word = 32'h1100;

    // Compare, period and setup registers all sit above this offset
    localparam logic [31:0] compare_base = 32'h100;

    function automatic logic [31:0] compare_low_offset(input int unsigned i);
        return compare_base + 32'(4 * i);
    endfunction

    function automatic logic [31:0] compare_high_offset(input int unsigned i,
                                                        input int unsigned n_channels);
        return compare_base + 32'(4 * (i + n_channels));
    endfunction

    function automatic logic [31:0] period_offset(input int unsigned n_channels);
        return compare_base + 32'(4 * (3 * n_channels + 1));
    endfunction

    // The three setup writes, issued in index order 0, 1, 2
    function automatic logic [31:0] config_offset(input int unsigned k,
                                                  input int unsigned n_channels);
        case (k)
            0: return ctrl_offset;
            1: return compare_base + 32'(4 * (3 * n_channels + 5));
            default: return compare_base + 32'(4 * (3 * n_channels + 3));
        endcase
    endfunction

    function automatic logic [31:0] config_word(input int unsigned k);
        case (k)
            0: return ctrl_disable_word;
            1: return 32'h1;
            default: return 32'hff;
        endcase
    endfunction

endpackage

`default_nettype wire
